//--- bench/MemExecBench.sv
`timescale 1ns/1ps
// Testbench top for the memory execution subsystem
// Drives random ops from an LCG, holds fences under stall so the flush
// sequencer can finish, and bounds the run with a cycle limit
module MemExecBench;

    localparam int flushCycles = 6;
    localparam int opCount     = 4000;
    localparam int cycleLimit  = opCount * (flushCycles + 4) + 100;

    logic                     clk;
    logic                     arstN;
    logic                     stall;
    logic                     clear;
    logic                     inValid;
    MemPipePkg::MemOpType     inOpType;
    MemPipePkg::AlPtrPath     inAlPtr;
    MemPipePkg::ImmPath       inImm;
    logic                     inIsFenceI;
    MemPipePkg::CsrCode       inCsrCode;
    logic                     inCsrIsImm;
    MemPipePkg::CsrImmPath    inCsrImm;
    MemPipePkg::DataPath      inOperandA;
    MemPipePkg::DataPath      inOperandB;
    logic                     bypassValidA;
    logic                     bypassValidB;
    MemPipePkg::DataPath      bypassDataA;
    MemPipePkg::DataPath      bypassDataB;
    logic                     bypassReadyA;
    logic                     bypassReadyB;
    logic                     recoveryActive;
    MemPipePkg::AlPtrPath     flushHead;
    MemPipePkg::AlPtrPath     flushTail;
    logic                     flushAll;
    logic                     dcReadReq;
    MemPipePkg::PhyAddrPath   dcReadAddr;
    logic                     dcReadUncached;
    logic                     outValid;
    MemPipePkg::MemOpType     outOpType;
    MemPipePkg::AlPtrPath     outAlPtr;
    MemPipePkg::AddrPath      outAddr;
    MemPipePkg::PhyAddrPath   outPhyAddr;
    MemPipePkg::MemMapType    outMemMap;
    MemPipePkg::DataPath      outData;
    logic                     outRegValid;
    int                       errorCount;
    int                       checkCount;

    logic [31:0]              lcgState;
    int                       cycleCount;
    int                       fenceHold;

    MemExecTop #(.flushCycles(flushCycles)) uut (.*);

    MemExecChecker #(.flushCycles(flushCycles)) scoreboard (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Two LCG steps, upper halves joined
    function automatic logic [31:0] nextRandom();
        logic [15:0] high;
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        high = lcgState[31:16];
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {high, lcgState[31:16]};
    endfunction

    // Operand aimed at one of the regions most of the time
    function automatic logic [31:0] makeOperand();
        logic [31:0] pick;
        logic [31:0] low;
        logic [3:0]  tag;
        pick = nextRandom();
        low  = nextRandom();
        case (pick[1:0])
            2'd0:    tag = 4'h8;
            2'd1:    tag = 4'h4;
            2'd2:    tag = 4'h1;
            default: tag = pick[31:28];
        endcase
        return {tag, low[27:0]};
    endfunction

    task automatic driveCycle();
        logic [31:0] r;
        logic [31:0] kind;
        logic        stallNow;
        logic [2:0]  opSel;
        r = nextRandom();
        stallNow = (r % 100 < 10) || (fenceHold > 0);
        if (fenceHold > 0) begin
            fenceHold = fenceHold - 1;
        end
        stall <= stallNow;
        r = nextRandom();
        clear <= (r % 100 < 5);
        r = nextRandom();
        inValid <= (r % 8 != 0);
        kind = nextRandom();
        opSel = 3'(kind % 5);
        inOpType   <= MemPipePkg::MemOpType'(opSel);
        inIsFenceI <= (kind[15:12] != 4'h0);
        inCsrCode  <= MemPipePkg::CsrCode'(kind[17:16] % 2'd3);
        inCsrIsImm <= kind[20];
        inCsrImm   <= kind[25:21];
        r = nextRandom();
        inAlPtr <= r[5:0];
        if (opSel == 3'd2) begin
            inImm <= 12'h2FE + 12'(r[18:16]);
        end else begin
            inImm <= r[31:20];
        end
        // Give a captured fence time to finish its flush
        if (opSel == 3'd3 && !stallNow) begin
            fenceHold = int'(r[15:8]) % (flushCycles + 3);
        end
        inOperandA  <= makeOperand();
        inOperandB  <= nextRandom();
        bypassDataA <= makeOperand();
        bypassDataB <= nextRandom();
        r = nextRandom();
        bypassValidA <= r[3];
        bypassValidB <= r[7];
        bypassReadyA <= (r[11:9] != 3'd0);
        bypassReadyB <= (r[15:13] != 3'd0);
        recoveryActive <= (r[31:16] % 100 < 10);
        r = nextRandom();
        flushHead <= r[5:0];
        flushTail <= r[13:8];
        flushAll  <= (r[19:16] == 4'h0);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Run did not finish within %0d cycles", cycleLimit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        lcgState = 32'd42;
        cycleCount = 0;
        fenceHold = 0;
        arstN = 1'b0;
        stall = 1'b0;
        clear = 1'b0;
        // A valid load waits at the inputs through reset
        inValid = 1'b1;
        inOpType = MemPipePkg::opLoad;
        inAlPtr = '0;
        inImm = '0;
        inIsFenceI = 1'b0;
        inCsrCode = MemPipePkg::csrWrite;
        inCsrIsImm = 1'b0;
        inCsrImm = '0;
        inOperandA = '0;
        inOperandB = '0;
        bypassValidA = 1'b0;
        bypassValidB = 1'b0;
        bypassDataA = '0;
        bypassDataB = '0;
        bypassReadyA = 1'b0;
        bypassReadyB = 1'b0;
        recoveryActive = 1'b0;
        flushHead = '0;
        flushTail = '0;
        flushAll = 1'b0;
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
        for (int i = 0; i < opCount; i++) begin
            @(posedge clk);
            driveCycle();
        end
        @(posedge clk);
        inValid <= 1'b0;
        stall <= 1'b0;
        repeat (3) @(posedge clk);
        $display("Checked %0d cycles, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- bench/MemExecChecker.sv
`timescale 1ns/1ps
// Reference model and comparator for the memory execution subsystem
// Tracks its own pipeline register, CSRs and flush sequencer, and
// compares every DUT output at the falling edge
module MemExecChecker #(
    parameter int flushCycles = 6
) (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     stall,
    input  logic                     clear,
    input  logic                     inValid,
    input  MemPipePkg::MemOpType     inOpType,
    input  MemPipePkg::AlPtrPath     inAlPtr,
    input  MemPipePkg::ImmPath       inImm,
    input  logic                     inIsFenceI,
    input  MemPipePkg::CsrCode       inCsrCode,
    input  logic                     inCsrIsImm,
    input  MemPipePkg::CsrImmPath    inCsrImm,
    input  MemPipePkg::DataPath      inOperandA,
    input  MemPipePkg::DataPath      inOperandB,
    input  logic                     bypassValidA,
    input  logic                     bypassValidB,
    input  MemPipePkg::DataPath      bypassDataA,
    input  MemPipePkg::DataPath      bypassDataB,
    input  logic                     bypassReadyA,
    input  logic                     bypassReadyB,
    input  logic                     recoveryActive,
    input  MemPipePkg::AlPtrPath     flushHead,
    input  MemPipePkg::AlPtrPath     flushTail,
    input  logic                     flushAll,
    input  logic                     dcReadReq,
    input  MemPipePkg::PhyAddrPath   dcReadAddr,
    input  logic                     dcReadUncached,
    input  logic                     outValid,
    input  MemPipePkg::MemOpType     outOpType,
    input  MemPipePkg::AlPtrPath     outAlPtr,
    input  MemPipePkg::AddrPath      outAddr,
    input  MemPipePkg::PhyAddrPath   outPhyAddr,
    input  MemPipePkg::MemMapType    outMemMap,
    input  MemPipePkg::DataPath      outData,
    input  logic                     outRegValid,
    output int                       errorCount,
    output int                       checkCount
);

    // Model pipeline register
    logic                   mValid;
    MemPipePkg::MemOpType   mOpType;
    MemPipePkg::AlPtrPath   mAlPtr;
    MemPipePkg::ImmPath     mImm;
    logic                   mIsFenceI;
    MemPipePkg::CsrCode     mCsrCode;
    logic                   mCsrIsImm;
    MemPipePkg::CsrImmPath  mCsrImm;
    MemPipePkg::DataPath    mOpA;
    MemPipePkg::DataPath    mOpB;

    // Model CSRs and sequencer, 0 idle, 1 flushing, 2 done
    MemPipePkg::DataPath    mCsr [4];
    int                     seqState;
    int                     seqCount;

    // Results of the falling-edge evaluation used at the next rising edge
    logic                   expCsrWe;
    int                     expCsrIndex;
    MemPipePkg::DataPath    expCsrNext;

    task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
            errorCount++;
        end
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    always @(negedge clk) begin : evaluate
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] addr;
        logic [31:0] wrVal;
        logic [31:0] oldCsr;
        logic [11:0] csrOff;
        logic [5:0]  span;
        logic [5:0]  offs;
        logic [1:0]  map;
        logic        aOk;
        logic        bOk;
        logic        flushHit;
        logic        fenceReq;
        logic        rv;
        logic        expValid;
        if (!arstN) begin
            compare("outValid", 32'(outValid), 32'h0);
            compare("dcReadReq", 32'(dcReadReq), 32'h0);
        end else begin
            checkCount++;
            opA = bypassValidA ? bypassDataA : mOpA;
            opB = bypassValidB ? bypassDataB : mOpB;
            aOk = !bypassValidA || bypassReadyA;
            bOk = !bypassValidB || bypassReadyB;
            addr = opA + {{20{mImm[11]}}, mImm};
            if (addr[31:28] == 4'h8) begin
                map = 2'd1;
            end else if (addr[31:28] == 4'h4) begin
                map = 2'd2;
            end else if (addr[31:28] == 4'h1) begin
                map = 2'd3;
            end else begin
                map = 2'd0;
            end
            // Ring distance from head decides membership
            span = flushTail - flushHead;
            offs = mAlPtr - flushHead;
            flushHit = recoveryActive && (flushAll || (offs < span));
            fenceReq = mValid && (mOpType == MemPipePkg::opFence) && mIsFenceI;
            if (mOpType == MemPipePkg::opLoad || mOpType == MemPipePkg::opStore) begin
                rv = aOk && bOk;
            end else if (mOpType == MemPipePkg::opCsr) begin
                rv = mCsrIsImm || aOk;
            end else begin
                rv = 1'b1;
            end
            if (fenceReq && seqState != 2) begin
                rv = 1'b0;
            end
            expValid = mValid && !stall && !clear && !flushHit;
            csrOff = mImm - 12'h300;
            oldCsr = (csrOff < 12'd4) ? mCsr[csrOff[1:0]] : 32'h0;
            wrVal = mCsrIsImm ? {27'h0, mCsrImm} : opA;

            compare("outValid", 32'(outValid), 32'(expValid));
            compare("dcReadReq", 32'(dcReadReq),
                    32'(expValid && rv && mOpType == MemPipePkg::opLoad));
            if (mValid) begin
                compare("outOpType", 32'(outOpType), 32'(mOpType));
                compare("outAlPtr", 32'(outAlPtr), 32'(mAlPtr));
                compare("outAddr", outAddr, addr);
                compare("outPhyAddr", 32'(outPhyAddr), {4'h0, addr[27:0]});
                compare("dcReadAddr", 32'(dcReadAddr), {4'h0, addr[27:0]});
                compare("outMemMap", 32'(outMemMap), 32'(map));
                compare("dcReadUncached", 32'(dcReadUncached), 32'(map != 2'd1));
                compare("outRegValid", 32'(outRegValid), 32'(rv));
                compare("outData", outData, (mOpType == MemPipePkg::opCsr) ? oldCsr : opB);
            end

            expCsrWe = expValid && rv && (mOpType == MemPipePkg::opCsr) && (csrOff < 12'd4);
            expCsrIndex = int'(csrOff[1:0]);
            case (mCsrCode)
                MemPipePkg::csrWrite: expCsrNext = wrVal;
                MemPipePkg::csrSet:   expCsrNext = oldCsr | wrVal;
                MemPipePkg::csrClear: expCsrNext = oldCsr & ~wrVal;
                default:              expCsrNext = oldCsr;
            endcase
        end
    end

    always @(posedge clk or negedge arstN) begin : advance
        logic fenceReq;
        if (!arstN) begin
            mValid = 1'b0;
            for (int i = 0; i < 4; i++) begin
                mCsr[i] = '0;
            end
            seqState = 0;
            seqCount = 0;
        end else begin
            fenceReq = mValid && (mOpType == MemPipePkg::opFence) && mIsFenceI;
            if (expCsrWe) begin
                mCsr[expCsrIndex] = expCsrNext;
            end
            case (seqState)
                0: begin
                    seqCount = 0;
                    if (fenceReq) begin
                        seqState = 1;
                    end
                end
                1: begin
                    if (seqCount == flushCycles - 1) begin
                        seqState = 2;
                        seqCount = 0;
                    end else begin
                        seqCount++;
                    end
                end
                default: begin
                    if (!fenceReq) begin
                        seqState = 0;
                    end
                end
            endcase
            if (!stall) begin
                mValid    = inValid;
                mOpType   = inOpType;
                mAlPtr    = inAlPtr;
                mImm      = inImm;
                mIsFenceI = inIsFenceI;
                mCsrCode  = inCsrCode;
                mCsrIsImm = inCsrIsImm;
                mCsrImm   = inCsrImm;
                mOpA      = inOperandA;
                mOpB      = inOperandB;
            end
        end
    end

endmodule

//--- memExecTop.f
source/MemPipePkg.sv
source/CsrFile.sv
source/CacheFlushSequencer.sv
source/MemExecStage.sv
source/MemExecTop.sv
bench/MemExecChecker.sv
bench/MemExecBench.sv

//--- runSim.sh
#!/usr/bin/env bash
# Builds the memory execution testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f memExecTop.f \
    --top-module MemExecBench \
    -Mdir obj_dir \
    -o memExecSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/memExecSim)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TESTS PASSED" <<< "$simOutput"; then
    exit 0
else
    exit 1
fi

//--- source/CacheFlushSequencer.sv
`timescale 1ns/1ps
// Cache flush sequencer
// Answers a flush request with completion after flushCycles cycles and
// holds completion until the request drops
module CacheFlushSequencer #(
    parameter int flushCycles = 6
) (
    input  logic  clk,
    input  logic  arstN,
    input  logic  cacheFlushReq,
    output logic  cacheFlushComplete
);

    localparam int countWidth = $clog2(flushCycles + 1);

    typedef enum logic [1:0] {
        idle,
        flushing,
        done
    } FlushState;

    FlushState               state;
    logic [countWidth-1:0]   count;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= idle;
            count <= '0;
        end else begin
            case (state)
                idle: begin
                    count <= '0;
                    if (cacheFlushReq) begin
                        state <= flushing;
                    end
                end
                // Runs to the end even if the request drops
                flushing: begin
                    if (count == countWidth'(flushCycles - 1)) begin
                        state <= done;
                        count <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: begin
                    if (!cacheFlushReq) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

    assign cacheFlushComplete = (state == done);

    assert property (@(posedge clk) disable iff (!arstN) count <= countWidth'(flushCycles))
        else $error("flush counter overran: %0d", count);

endmodule

//--- source/CsrFile.sv
`timescale 1ns/1ps
// Machine CSR file, four registers at 0x300 to 0x303
// Read returns the old value combinationally; write, set and clear
// update on the clock edge
module CsrFile (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  csrWe,
    input  MemPipePkg::ImmPath    csrNumber,
    input  MemPipePkg::DataPath   csrWriteValue,
    input  MemPipePkg::CsrCode    csrCode,
    output MemPipePkg::DataPath   csrReadOut
);

    MemPipePkg::DataPath  csrRegs [MemPipePkg::csrCount];
    MemPipePkg::ImmPath   csrOffset;
    logic [1:0]           csrIndex;
    logic                 inWindow;
    MemPipePkg::DataPath  nextValue;

    assign csrOffset = csrNumber - MemPipePkg::csrBaseNumber;
    assign csrIndex  = csrOffset[1:0];
    // Offset wraps for numbers below the base, so one compare covers both ends
    assign inWindow  = (csrOffset < MemPipePkg::ImmPath'(MemPipePkg::csrCount));

    assign csrReadOut = inWindow ? csrRegs[csrIndex] : '0;

    always_comb begin
        case (csrCode)
            MemPipePkg::csrWrite: nextValue = csrWriteValue;
            MemPipePkg::csrSet:   nextValue = csrReadOut | csrWriteValue;
            MemPipePkg::csrClear: nextValue = csrReadOut & ~csrWriteValue;
            default:              nextValue = csrReadOut;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < MemPipePkg::csrCount; i++) begin
                csrRegs[i] <= '0;
            end
        end else if (csrWe && inWindow) begin
            csrRegs[csrIndex] <= nextValue;
        end
    end

    // The stage gates csrWe from its own valid and stall logic
    assert property (@(posedge clk) disable iff (!arstN) !$isunknown(csrWe))
        else $error("csrWe unknown");

endmodule

//--- source/MemExecStage.sv
`timescale 1ns/1ps
// Memory execution stage for a single issue lane
// Holds the issued op for one cycle, selects bypassed operands, forms and
// classifies the address, checks the selective flush range and raises
// the load, CSR and FENCE.I flush requests
module MemExecStage (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     stall,
    input  logic                     clear,
    input  logic                     inValid,
    input  MemPipePkg::MemOpType     inOpType,
    input  MemPipePkg::AlPtrPath     inAlPtr,
    input  MemPipePkg::ImmPath       inImm,
    input  logic                     inIsFenceI,
    input  MemPipePkg::CsrCode       inCsrCode,
    input  logic                     inCsrIsImm,
    input  MemPipePkg::CsrImmPath    inCsrImm,
    input  MemPipePkg::DataPath      inOperandA,
    input  MemPipePkg::DataPath      inOperandB,
    input  logic                     bypassValidA,
    input  logic                     bypassValidB,
    input  MemPipePkg::DataPath      bypassDataA,
    input  MemPipePkg::DataPath      bypassDataB,
    input  logic                     bypassReadyA,
    input  logic                     bypassReadyB,
    input  logic                     recoveryActive,
    input  MemPipePkg::AlPtrPath     flushHead,
    input  MemPipePkg::AlPtrPath     flushTail,
    input  logic                     flushAll,
    input  logic                     cacheFlushComplete,
    input  MemPipePkg::DataPath      csrReadOut,
    output logic                     dcReadReq,
    output MemPipePkg::PhyAddrPath   dcReadAddr,
    output logic                     dcReadUncached,
    output logic                     cacheFlushReq,
    output logic                     csrWe,
    output MemPipePkg::ImmPath       csrNumber,
    output MemPipePkg::DataPath      csrWriteValue,
    output MemPipePkg::CsrCode       csrCode,
    output logic                     outValid,
    output MemPipePkg::MemOpType     outOpType,
    output MemPipePkg::AlPtrPath     outAlPtr,
    output MemPipePkg::AddrPath      outAddr,
    output MemPipePkg::PhyAddrPath   outPhyAddr,
    output MemPipePkg::MemMapType    outMemMap,
    output MemPipePkg::DataPath      outData,
    output logic                     outRegValid
);

    // Pipeline register
    logic                    pipeValid;
    MemPipePkg::MemOpType    pipeOpType;
    MemPipePkg::AlPtrPath    pipeAlPtr;
    MemPipePkg::ImmPath      pipeImm;
    logic                    pipeIsFenceI;
    MemPipePkg::CsrCode      pipeCsrCode;
    logic                    pipeCsrIsImm;
    MemPipePkg::CsrImmPath   pipeCsrImm;
    MemPipePkg::DataPath     pipeOperandA;
    MemPipePkg::DataPath     pipeOperandB;

    MemPipePkg::DataPath     fuOpA;
    MemPipePkg::DataPath     fuOpB;
    logic                    opAValid;
    logic                    opBValid;
    logic                    regValid;
    logic                    inRange;
    logic                    flush;
    MemPipePkg::AddrPath     addr;
    MemPipePkg::MemMapType   memMap;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pipeValid <= 1'b0;
        end else if (!stall) begin
            pipeValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pipeOpType   <= inOpType;
            pipeAlPtr    <= inAlPtr;
            pipeImm      <= inImm;
            pipeIsFenceI <= inIsFenceI;
            pipeCsrCode  <= inCsrCode;
            pipeCsrIsImm <= inCsrIsImm;
            pipeCsrImm   <= inCsrImm;
            pipeOperandA <= inOperandA;
            pipeOperandB <= inOperandB;
        end
    end

    // Operands, bypass wins when its valid bit is set
    assign fuOpA    = bypassValidA ? bypassDataA : pipeOperandA;
    assign fuOpB    = bypassValidB ? bypassDataB : pipeOperandB;
    assign opAValid = !bypassValidA || bypassReadyA;
    assign opBValid = !bypassValidB || bypassReadyB;

    // Address unit
    assign addr = fuOpA + {{(MemPipePkg::addrWidth - MemPipePkg::immWidth){pipeImm[11]}},
                           pipeImm};

    always_comb begin
        case (addr[31:28])
            MemPipePkg::mapMemoryTag:   memMap = MemPipePkg::mapMemory;
            MemPipePkg::mapUncachedTag: memMap = MemPipePkg::mapUncached;
            MemPipePkg::mapIoTag:       memMap = MemPipePkg::mapIo;
            default:                    memMap = MemPipePkg::mapNone;
        endcase
    end

    // Half-open ring range head..tail, empty when both match
    always_comb begin
        if (flushHead == flushTail) begin
            inRange = 1'b0;
        end else if (flushHead < flushTail) begin
            inRange = (pipeAlPtr >= flushHead) && (pipeAlPtr < flushTail);
        end else begin
            inRange = (pipeAlPtr >= flushHead) || (pipeAlPtr < flushTail);
        end
    end

    assign flush = recoveryActive && (flushAll || inRange);

    // FENCE.I holds the flush request while it sits here
    assign cacheFlushReq = pipeValid && (pipeOpType == MemPipePkg::opFence) && pipeIsFenceI;

    always_comb begin
        case (pipeOpType)
            MemPipePkg::opLoad,
            MemPipePkg::opStore: regValid = opAValid && opBValid;
            MemPipePkg::opCsr:   regValid = pipeCsrIsImm || opAValid;
            default:             regValid = 1'b1;
        endcase
        // Replay the fence until the caches are flushed
        if (cacheFlushReq && !cacheFlushComplete) begin
            regValid = 1'b0;
        end
    end

    assign outValid = pipeValid && !stall && !clear && !flush;

    // Data-cache read
    assign dcReadReq      = outValid && regValid && (pipeOpType == MemPipePkg::opLoad);
    assign dcReadAddr     = addr[MemPipePkg::phyAddrWidth-1:0];
    assign dcReadUncached = (memMap != MemPipePkg::mapMemory);

    // CSR request
    assign csrWe         = outValid && regValid && (pipeOpType == MemPipePkg::opCsr);
    assign csrNumber     = pipeImm;
    assign csrCode       = pipeCsrCode;
    assign csrWriteValue = pipeCsrIsImm ?
        {{(MemPipePkg::dataWidth - MemPipePkg::csrImmWidth){1'b0}}, pipeCsrImm} : fuOpA;

    // Next stage
    assign outOpType   = pipeOpType;
    assign outAlPtr    = pipeAlPtr;
    assign outAddr     = addr;
    assign outPhyAddr  = addr[MemPipePkg::phyAddrWidth-1:0];
    assign outMemMap   = memMap;
    assign outData     = (pipeOpType == MemPipePkg::opCsr) ? csrReadOut : fuOpB;
    assign outRegValid = regValid;

    assert property (@(posedge clk) disable iff (!arstN)
        dcReadReq |-> (pipeOpType == MemPipePkg::opLoad))
        else $error("dcReadReq with op type %0d", pipeOpType);

    assert property (@(posedge clk) disable iff (!arstN) stall |-> !outValid)
        else $error("outValid high during stall");

    // Flush request only from a FENCE.I captured last cycle or held by stall
    assert property (@(posedge clk) disable iff (!arstN)
        cacheFlushReq |-> $past(stall ? cacheFlushReq :
            (inValid && (inOpType == MemPipePkg::opFence) && inIsFenceI)))
        else $error("cacheFlushReq with op type %0d", pipeOpType);

endmodule

//--- source/MemExecTop.sv
`timescale 1ns/1ps
// Memory execution subsystem top
// Connects the execution stage to the CSR file and the cache flush sequencer
module MemExecTop #(
    parameter int flushCycles = 6
) (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     stall,
    input  logic                     clear,
    input  logic                     inValid,
    input  MemPipePkg::MemOpType     inOpType,
    input  MemPipePkg::AlPtrPath     inAlPtr,
    input  MemPipePkg::ImmPath       inImm,
    input  logic                     inIsFenceI,
    input  MemPipePkg::CsrCode       inCsrCode,
    input  logic                     inCsrIsImm,
    input  MemPipePkg::CsrImmPath    inCsrImm,
    input  MemPipePkg::DataPath      inOperandA,
    input  MemPipePkg::DataPath      inOperandB,
    input  logic                     bypassValidA,
    input  logic                     bypassValidB,
    input  MemPipePkg::DataPath      bypassDataA,
    input  MemPipePkg::DataPath      bypassDataB,
    input  logic                     bypassReadyA,
    input  logic                     bypassReadyB,
    input  logic                     recoveryActive,
    input  MemPipePkg::AlPtrPath     flushHead,
    input  MemPipePkg::AlPtrPath     flushTail,
    input  logic                     flushAll,
    output logic                     dcReadReq,
    output MemPipePkg::PhyAddrPath   dcReadAddr,
    output logic                     dcReadUncached,
    output logic                     outValid,
    output MemPipePkg::MemOpType     outOpType,
    output MemPipePkg::AlPtrPath     outAlPtr,
    output MemPipePkg::AddrPath      outAddr,
    output MemPipePkg::PhyAddrPath   outPhyAddr,
    output MemPipePkg::MemMapType    outMemMap,
    output MemPipePkg::DataPath      outData,
    output logic                     outRegValid
);

    // CSR port
    logic                  csrWe;
    MemPipePkg::ImmPath    csrNumber;
    MemPipePkg::DataPath   csrWriteValue;
    MemPipePkg::CsrCode    csrCode;
    MemPipePkg::DataPath   csrReadOut;

    // Flush handshake
    logic                  cacheFlushReq;
    logic                  cacheFlushComplete;

    MemExecStage stage (.*);

    CsrFile csrFile (.*);

    CacheFlushSequencer #(
        .flushCycles(flushCycles)
    ) flushSequencer (.*);

endmodule

//--- source/MemPipePkg.sv
// Shared definitions for the memory execution subsystem
// Data and address widths, op and region encodings, memory-map tags
// and the CSR window
package MemPipePkg;

    localparam int dataWidth   = 32;
    localparam int addrWidth   = 32;
    localparam int phyAddrWidth = 28;
    localparam int immWidth    = 12;
    localparam int alPtrWidth  = 6;
    localparam int csrImmWidth = 5;

    typedef logic [dataWidth-1:0]    DataPath;
    typedef logic [addrWidth-1:0]    AddrPath;
    typedef logic [phyAddrWidth-1:0] PhyAddrPath;
    // Address offset, doubles as the CSR number
    typedef logic [immWidth-1:0]     ImmPath;
    // Active-list ring of 64 entries
    typedef logic [alPtrWidth-1:0]   AlPtrPath;
    typedef logic [csrImmWidth-1:0]  CsrImmPath;

    typedef enum logic [2:0] {
        opLoad,
        opStore,
        opCsr,
        opFence,
        opNop
    } MemOpType;

    typedef enum logic [1:0] {
        csrWrite,
        csrSet,
        csrClear
    } CsrCode;

    typedef enum logic [1:0] {
        mapNone,
        mapMemory,
        mapUncached,
        mapIo
    } MemMapType;

    // Region tags in address bits 31:28
    localparam logic [3:0] mapMemoryTag   = 4'h8;
    localparam logic [3:0] mapUncachedTag = 4'h4;
    localparam logic [3:0] mapIoTag       = 4'h1;

    // Machine CSR window 0x300 to 0x303
    localparam ImmPath csrBaseNumber = 12'h300;
    localparam int     csrCount      = 4;

endpackage
